//--- frontendTop.f
+incdir+include
hdl/fetchPkg.sv
hdl/pcGen.sv
hdl/instrMem.sv
hdl/fetchStage.sv
hdl/instrDecode.sv
hdl/frontendTop.sv
tests/frontendTb.sv

//--- tests/frontendTb.sv
`default_nettype none

`include "fetch_cfg.svh"

module frontendTb
	import fetchPkg::*;
();

	// major opcodes in opClass_t order with an unlisted code as entry 11
	localparam logic [83:0] opcodeTable = {7'b1011011, 7'b1110011, 7'b0001111, 7'b0110011,
		7'b0010011, 7'b0100011, 7'b0000011, 7'b1100011, 7'b1100111, 7'b1101111,
		7'b0010111, 7'b0110111};

	logic             clk, nrst, stall, exceptionPending, debugWe;
	pcSel_t           pcSelect, sel;
	logic [`XLEN-1:0] target, epc, debugAddr, debugInstr, fetchPc, fetchInstr, decPc, decImm;
	logic             fetchValid, fetchMisaligned, decValid, decMisaligned;
	opClass_t         decOp;
	logic [4:0]       decRd, decRs1, decRs2, rDecRd, rDecRs1, rDecRs2;
	logic [2:0]       decFunct3, rDecFunct3;
	logic [3:0]       rDecOp;
	logic [`XLEN-1:0] refMem [`IMEM_WORDS];	// program image
	logic [`XLEN-1:0] rPc, rPc2, rInstr2, rDecPc, rDecImm, r, held, snapDec;
	logic             rValid2, rMis2, rDecValid, rDecMis;
	logic [31:0]      rngState = 32'd52;
	int               errorCount = 0, illegalSeen = 0, edges;

	frontendTop frontendTop_i
	(
		.clk(clk), .nrst(nrst), .stall(stall), .pcSelect(pcSelect), .target(target),
		.exceptionPending(exceptionPending), .epc(epc), .debugWe(debugWe),
		.debugAddr(debugAddr), .debugInstr(debugInstr), .fetchPc(fetchPc),
		.fetchInstr(fetchInstr), .fetchValid(fetchValid), .fetchMisaligned(fetchMisaligned),
		.decValid(decValid), .decPc(decPc), .decOp(decOp), .decRd(decRd), .decRs1(decRs1),
		.decRs2(decRs2), .decFunct3(decFunct3), .decImm(decImm), .decMisaligned(decMisaligned)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] randWord();
		rngState = rngState ^ (rngState << 13);	// xorshift32
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	// aligned and well inside the 64 loaded words
	function automatic logic [31:0] randAddr();
		return (randWord() % 48) * 4;
	endfunction

	// mostly sequential
	function automatic pcSel_t pickSel(input logic [2:0] b);
		case (b)
			3'd0:    return pcTarget;
			3'd1:    return pcHold;
			3'd2:    return pcReset;
			default: return pcNext;
		endcase
	endfunction

	// every listed opcode ends in 11, so compressed space falls through too
	function automatic logic [3:0] refClass(input logic [31:0] w);
		for (logic [3:0] k = 0; k < 11; k++)
			if (w[6:0] == opcodeTable[k*7 +: 7])
				return k;
		return opIllegal;
	endfunction

	function automatic logic [31:0] refImm(input logic [31:0] w, input logic [3:0] op);
		logic [31:0] s;
		s = {32{w[31]}};	// sign fill
		case (op)
			opLoad, opJalr, opImm, opSystem: return {s[31:12], w[31:20]};
			opStore:        return {s[31:12], w[31:25], w[11:7]};
			opBranch:       return {s[31:13], w[31], w[7], w[30:25], w[11:8], 1'b0};
			opLui, opAuipc: return {w[31:12], 12'h000};
			opJal:          return {s[31:21], w[31], w[19:12], w[20], w[30:21], 1'b0};
			default:        return '0;
		endcase
	endfunction

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1, "run stopped at %0t", $time);
	endtask

	task automatic check(input logic [31:0] actual, expected, input string what);
		if (actual !== expected)
		begin
			errorCount++;
			abortRun($sformatf("** Error at time %0t: %s is %h, expected %h",
				$time, what, actual, expected));
		end
	endtask

	// inputs change 2 units after the edge
	task automatic drive(input logic st, input pcSel_t s, input logic [31:0] tgt,
		input logic exc, input logic [31:0] ep);
		stall = st;
		pcSelect = s;
		target = tgt;
		exceptionPending = exc;
		epc = ep;
		@(posedge clk);
		#2;
	endtask

	// reference pipes update decode first so it sees the old fetch outputs
	always @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			rPc = `RESET_VECTOR;
			{rPc2, rInstr2, rDecPc, rDecImm} = '0;
			{rValid2, rMis2, rDecValid, rDecMis} = '0;
			{rDecRd, rDecRs1, rDecRs2, rDecFunct3} = '0;
			rDecOp = opLui;
		end
		else
		begin
			if (!stall)
			begin
				rDecValid = rValid2;
				rDecMis = rMis2;
				rDecPc = rPc2;
				rDecOp = refClass(rInstr2);
				rDecImm = refImm(rInstr2, rDecOp);
				rDecRd = rInstr2[11:7];
				rDecRs1 = rInstr2[19:15];
				rDecRs2 = rInstr2[24:20];
				rDecFunct3 = rInstr2[14:12];
				rMis2 = |rPc[1:0];
				rInstr2 = rMis2 ? `NOP_INSTR : refMem[(rPc >> 2) % `IMEM_WORDS];
				rPc2 = rPc;
				rValid2 = 1'b1;
				if (exceptionPending)
					rPc = epc;	// beats any select
				else if (pcSelect == pcReset)
					rPc = `RESET_VECTOR;
				else if (pcSelect == pcTarget)
					rPc = target;
				else if (pcSelect == pcNext)
					rPc = rPc + 4;
			end
			if (debugWe)
				refMem[(debugAddr >> 2) % `IMEM_WORDS] = debugInstr;	// after the read
		end
	end

	// compare mid-cycle where outputs have settled
	always @(negedge clk)
	begin
		if (nrst)
		begin
			check(fetchPc, rPc2, "fetchPc");
			check(fetchInstr, rInstr2, "fetchInstr");
			check(fetchValid, rValid2, "fetchValid");
			check(fetchMisaligned, rMis2, "fetchMisaligned");
			check(decValid, rDecValid, "decValid");
			check(decPc, rDecPc, "decPc");
			check(decOp, rDecOp, "decOp");
			check(decRd, rDecRd, "decRd");
			check(decRs1, rDecRs1, "decRs1");
			check(decRs2, rDecRs2, "decRs2");
			check(decFunct3, rDecFunct3, "decFunct3");
			check(decImm, rDecImm, "decImm");
			check(decMisaligned, rDecMis, "decMisaligned");
			if (decValid && decOp == opIllegal)
				illegalSeen++;
		end
	end

	initial
	begin
		nrst = 1'b0;
		stall = 1'b1;
		pcSelect = pcNext;
		{target, epc, exceptionPending} = '0;
		{debugWe, debugAddr, debugInstr} = '0;
		repeat (4) @(posedge clk);
		#2;
		nrst = 1'b1;
		// program load under stall with every 13th word in compressed space
		for (int i = 0; i < 64; i++)
		begin
			r = randWord();
			debugWe = 1'b1;
			debugAddr = i * 4;
			debugInstr = (i % 13 == 12) ? {r[31:2], 2'b01}
				: {r[31:7], opcodeTable[(i % 13) * 7 +: 7]};
			@(posedge clk);
			#2;
		end
		debugWe = 1'b0;
		edges = 0;
		while (!decValid)
		begin
			if (edges == 8)
				abortRun("timeout waiting for the first decValid");
			drive(1'b0, pcNext, '0, 1'b0, '0);
			edges++;
		end
		check(edges, 2, "unstalled edges to first decValid");
		for (int i = 0; i < 20; i++)
		begin
			check(decPc, `RESET_VECTOR + i * 4, "sequential decPc");
			drive(1'b0, pcNext, '0, 1'b0, '0);
		end
		held = randAddr();
		drive(1'b0, pcTarget, held, 1'b0, '0);
		drive(1'b0, pcNext, '0, 1'b0, '0);
		check(fetchPc, held, "fetchPc after redirect");
		drive(1'b0, pcNext, '0, 1'b0, '0);
		check(decPc, held, "decPc after redirect");
		drive(1'b0, pcReset, '0, 1'b0, '0);
		repeat (3)
		begin
			drive(1'b0, pcHold, '0, 1'b0, '0);
			check(fetchPc, `RESET_VECTOR, "fetchPc under pcHold");
		end
		repeat (4)
		begin
			held = randAddr();
			r = randWord();
			drive(1'b0, pickSel(r[2:0]), randAddr(), 1'b1, held);
			drive(1'b0, pcNext, '0, 1'b0, '0);
			check(fetchPc, held, "fetchPc after exception");
		end
		// stalled target is ignored
		held = fetchPc;
		snapDec = decPc;
		repeat (3)
		begin
			drive(1'b1, pcTarget, randAddr(), 1'b0, '0);
			check(fetchPc, held, "fetchPc under stall");
			check(decPc, snapDec, "decPc under stall");
		end
		drive(1'b0, pcNext, '0, 1'b0, '0);
		check(decPc, held, "decPc after stall");
		for (int i = 0; i < 200; i++)
		begin
			r = randWord();
			sel = pickSel(r[6:4]);
			if (sel == pcNext && rPc >= 240)
				sel = pcTarget;	// keep inside the loaded words
			drive(r[1:0] == 2'b00, sel, randAddr(), r[11:8] == 4'h0, randAddr());
		end
		drive(1'b0, pcTarget, 32'h42, 1'b0, '0);
		edges = 0;
		while (!fetchMisaligned)
		begin
			if (edges == 4)
				abortRun("timeout waiting for fetchMisaligned");
			drive(1'b0, pcNext, '0, 1'b0, '0);
			edges++;
		end
		check(fetchInstr, `NOP_INSTR, "fetchInstr on misaligned pc");
		drive(1'b0, pcTarget, 32'h10, 1'b0, '0);
		check(decMisaligned, 1'b1, "decMisaligned");
		check(decOp, opImm, "decOp of substituted nop");
		check(decImm, '0, "decImm of substituted nop");
		// full sweep so every loaded word gets decoded
		drive(1'b0, pcReset, '0, 1'b0, '0);
		repeat (63) drive(1'b0, pcNext, '0, 1'b0, '0);
		repeat (3) drive(1'b0, pcReset, '0, 1'b0, '0);
		check(illegalSeen != 0, 1, "illegal words seen at decode");
		if (errorCount == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/frontendTop.sv
`default_nettype none

`include "fetch_cfg.svh"

module frontendTop
	import fetchPkg::*;
(
	input  logic              clk,
	input  logic              nrst,
	input  logic              stall,	// freezes both stages
	input  pcSel_t            pcSelect,
	input  logic [`XLEN-1:0]  target,
	input  logic              exceptionPending,
	input  logic [`XLEN-1:0]  epc,
	input  logic              debugWe,	// program load port
	input  logic [`XLEN-1:0]  debugAddr,
	input  logic [`XLEN-1:0]  debugInstr,
	output logic [`XLEN-1:0]  fetchPc,
	output logic [`XLEN-1:0]  fetchInstr,
	output logic              fetchValid,
	output logic              fetchMisaligned,
	output logic              decValid,
	output logic [`XLEN-1:0]  decPc,
	output opClass_t          decOp,
	output logic [4:0]        decRd,
	output logic [4:0]        decRs1,
	output logic [4:0]        decRs2,
	output logic [2:0]        decFunct3,
	output logic [`XLEN-1:0]  decImm,
	output logic              decMisaligned
);

	// fetch to decode
	logic [`XLEN-1:0] pc2;
	logic [`XLEN-1:0] instr2;
	logic             valid2;
	logic             misaligned2;

	fetchStage fetchStage_i
	(
		.clk              (clk),
		.nrst             (nrst),
		.stall            (stall),
		.pcSelect         (pcSelect),
		.target           (target),
		.epc              (epc),
		.exceptionPending (exceptionPending),
		.debugWe          (debugWe),
		.debugAddr        (debugAddr),
		.debugInstr       (debugInstr),
		.pc2              (pc2),
		.instr2           (instr2),
		.valid2           (valid2),
		.misaligned2      (misaligned2)
	);

	instrDecode instrDecode_i
	(
		.clk           (clk),
		.nrst          (nrst),
		.stall         (stall),
		.pc2           (pc2),
		.instr2        (instr2),
		.valid2        (valid2),
		.misaligned2   (misaligned2),
		.decValid      (decValid),
		.decMisaligned (decMisaligned),
		.decPc         (decPc),
		.decImm        (decImm),
		.decOp         (decOp),
		.decRd         (decRd),
		.decRs1        (decRs1),
		.decRs2        (decRs2),
		.decFunct3     (decFunct3)
	);

	// fetch stage also visible outside
	assign fetchPc         = pc2;
	assign fetchInstr      = instr2;
	assign fetchValid      = valid2;
	assign fetchMisaligned = misaligned2;

endmodule

`default_nettype wire

//--- hdl/instrDecode.sv
`default_nettype none

`include "fetch_cfg.svh"

module instrDecode
	import fetchPkg::*;
(
	input  logic              clk,
	input  logic              nrst,
	input  logic              stall,
	input  logic [`XLEN-1:0]  pc2,
	input  logic [`XLEN-1:0]  instr2,
	input  logic              valid2,
	input  logic              misaligned2,
	output logic              decValid,
	output logic              decMisaligned,
	output logic [`XLEN-1:0]  decPc,
	output logic [`XLEN-1:0]  decImm,	// sign extended
	output opClass_t          decOp,
	output logic [4:0]        decRd,
	output logic [4:0]        decRs1,
	output logic [4:0]        decRs2,
	output logic [2:0]        decFunct3
);

	opClass_t         opNext;
	logic [`XLEN-1:0] immNext;

	// major opcode class
	always_comb
	begin
		if (instr2[1:0] != 2'b11)
		begin
			opNext = opIllegal;	// compressed space, not supported
		end
		else
		begin
			case (instr2[6:0])
				7'b0110111: opNext = opLui;
				7'b0010111: opNext = opAuipc;
				7'b1101111: opNext = opJal;
				7'b1100111: opNext = opJalr;
				7'b1100011: opNext = opBranch;
				7'b0000011: opNext = opLoad;
				7'b0100011: opNext = opStore;
				7'b0010011: opNext = opImm;
				7'b0110011: opNext = opReg;
				7'b0001111: opNext = opFence;
				7'b1110011: opNext = opSystem;
				default:    opNext = opIllegal;
			endcase
		end
	end

	// immediate by format, sign bit always instr2[31]
	always_comb
	begin
		case (opNext)
			opLoad, opJalr, opImm, opSystem:	// I type
				immNext = {{20{instr2[31]}}, instr2[31:20]};
			opStore:	// S type
				immNext = {{20{instr2[31]}}, instr2[31:25], instr2[11:7]};
			opBranch:	// B type, bit 0 implied
				immNext = {{19{instr2[31]}}, instr2[31], instr2[7],
					instr2[30:25], instr2[11:8], 1'b0};
			opLui, opAuipc:	// U type, upper 20 bits
				immNext = {instr2[31:12], 12'b0};
			opJal:	// J type
				immNext = {{11{instr2[31]}}, instr2[31], instr2[19:12],
					instr2[20], instr2[30:21], 1'b0};
			default:
				immNext = '0;	// reg, fence, illegal
		endcase
	end

	// decode pipe
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			decValid      <= 1'b0;
			decMisaligned <= 1'b0;
			decPc         <= '0;
			decImm        <= '0;
			decOp         <= opLui;	// zero encoding
			decRd         <= '0;
			decRs1        <= '0;
			decRs2        <= '0;
			decFunct3     <= '0;
		end
		else if (!stall)
		begin
			decValid      <= valid2;
			decMisaligned <= misaligned2;
			decPc         <= pc2;
			decImm        <= immNext;
			decOp         <= opNext;
			decRd         <= instr2[11:7];	// fixed slots, any class
			decRs1        <= instr2[19:15];
			decRs2        <= instr2[24:20];
			decFunct3     <= instr2[14:12];
		end
	end

endmodule

`default_nettype wire

//--- hdl/fetchStage.sv
`default_nettype none

`include "fetch_cfg.svh"

module fetchStage
	import fetchPkg::*;
(
	input  logic              clk,
	input  logic              nrst,
	input  logic              stall,
	input  pcSel_t            pcSelect,
	input  logic [`XLEN-1:0]  target,
	input  logic [`XLEN-1:0]  epc,
	input  logic              exceptionPending,
	input  logic              debugWe,
	input  logic [`XLEN-1:0]  debugAddr,
	input  logic [`XLEN-1:0]  debugInstr,
	output logic [`XLEN-1:0]  pc2,	// pc at pipe #2
	output logic [`XLEN-1:0]  instr2,	// word for decode
	output logic              valid2,
	output logic              misaligned2	// pc2 had a low bit set
);

	logic [`XLEN-1:0] pc;	// pipe #1 pc
	logic [`XLEN-1:0] memData;	// registered memory word
	logic             pcMisaligned;

	pcGen pcGen_i
	(
		.clk              (clk),
		.nrst             (nrst),
		.stall            (stall),
		.pcSelect         (pcSelect),
		.target           (target),
		.epc              (epc),
		.exceptionPending (exceptionPending),
		.pc               (pc)
	);

	// read follows pipe #1 and freezes with it
	instrMem instrMem_i
	(
		.clk        (clk),
		.rdEn       (!stall),
		.rdAddr     (pc),
		.rdData     (memData),
		.debugWe    (debugWe),
		.debugAddr  (debugAddr),
		.debugInstr (debugInstr)
	);

	assign pcMisaligned = |pc[1:0];	// either low bit

	// pipe #2 lines up with the memory output
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			pc2         <= '0;
			valid2      <= 1'b0;
			misaligned2 <= 1'b0;
		end
		else if (!stall)
		begin
			pc2         <= pc;
			valid2      <= 1'b1;	// every unstalled edge fetches
			misaligned2 <= pcMisaligned;
		end
	end

	// zero until the first fetch lands
	// misaligned fetch turns into a nop
	always_comb
	begin
		if (!valid2)
			instr2 = '0;
		else if (misaligned2)
			instr2 = `NOP_INSTR;
		else
			instr2 = memData;
	end

	// a misaligned pc leaves pipe #1 as a flagged nop one edge later
	nopOnMisalign: assert property (
		@(posedge clk) disable iff (!nrst)
		(!stall && pcMisaligned) |=> (misaligned2 && (instr2 == `NOP_INSTR))
	)
	else $error("misaligned fetch at %h not replaced by nop", pc2);

endmodule

`default_nettype wire

//--- hdl/instrMem.sv
`default_nettype none

`include "fetch_cfg.svh"

module instrMem
(
	input  logic              clk,
	input  logic              rdEn,	// low holds rdData
	input  logic [`XLEN-1:0]  rdAddr,	// byte address
	output logic [`XLEN-1:0]  rdData,
	input  logic              debugWe,	// program load strobe
	input  logic [`XLEN-1:0]  debugAddr,	// byte address, word aligned
	input  logic [`XLEN-1:0]  debugInstr
);

	localparam int idxWidth = $clog2(`IMEM_WORDS);

	logic [`XLEN-1:0]    mem [`IMEM_WORDS];
	logic [idxWidth-1:0] rdIdx;
	logic [idxWidth-1:0] wrIdx;

	// word index, drop byte offset, wrap at depth
	assign rdIdx = rdAddr[idxWidth+1:2];
	assign wrIdx = debugAddr[idxWidth+1:2];

	// debug write ignores stall
	// read sees the old word when both hit the same index
	always_ff @(posedge clk)
	begin
		if (debugWe)
		begin
			mem[wrIdx] <= debugInstr;
		end
		if (rdEn)
		begin
			rdData <= mem[rdIdx];	// sync read
		end
	end

	// loader only ever writes whole words
	debugAligned: assert property (
		@(posedge clk)
		debugWe |-> (debugAddr[1:0] == 2'b00)
	)
	else $error("misaligned debug write to %h", debugAddr);

endmodule

`default_nettype wire

//--- hdl/pcGen.sv
`default_nettype none

`include "fetch_cfg.svh"

module pcGen
	import fetchPkg::*;
(
	input  logic              clk,
	input  logic              nrst,
	input  logic              stall,	// freezes pcReg
	input  pcSel_t            pcSelect,
	input  logic [`XLEN-1:0]  target,	// redirect address
	input  logic [`XLEN-1:0]  epc,	// exception vector
	input  logic              exceptionPending,
	output logic [`XLEN-1:0]  pc	// pipe #1 pc
);

	logic [`XLEN-1:0] pcReg;
	logic [`XLEN-1:0] nextPc;

	// next address, exception wins over any select
	always_comb
	begin
		if (exceptionPending)
		begin
			nextPc = epc;
		end
		else
		begin
			case (pcSelect)
				pcNext:   nextPc = pcReg + `XLEN'd4;	// byte address, one word ahead
				pcReset:  nextPc = `RESET_VECTOR;
				pcTarget: nextPc = target;
				pcHold:   nextPc = pcReg;	// same fetch again
				default:  nextPc = pcReg + `XLEN'd4;
			endcase
		end
	end

	// pipe #1
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			pcReg <= `RESET_VECTOR;
		end
		else if (!stall)
		begin
			pcReg <= nextPc;
		end
	end

	assign pc = pcReg;

	// a stalled cycle must leave the pc where it was
	pcStallHold: assert property (
		@(posedge clk) disable iff (!nrst)
		$past(stall) |-> (pc == $past(pc))
	)
	else $error("pc moved during stall");

endmodule

`default_nettype wire

//--- hdl/fetchPkg.sv
`default_nettype none

package fetchPkg;

	// next-pc source, exception redirect sits above all of these
	typedef enum logic [1:0]
	{
		pcNext   = 2'd0,	// sequential, pc + 4
		pcReset  = 2'd1,	// back to reset vector
		pcTarget = 2'd2,	// branch / jump target
		pcHold   = 2'd3	// refetch same address
	} pcSel_t;

	// major opcode class seen by decode
	// opLui is the all-zero encoding, used as the reset value
	typedef enum logic [3:0]
	{
		opLui     = 4'd0,	// 0110111
		opAuipc   = 4'd1,	// 0010111
		opJal     = 4'd2,	// 1101111
		opJalr    = 4'd3,	// 1100111
		opBranch  = 4'd4,	// 1100011
		opLoad    = 4'd5,	// 0000011
		opStore   = 4'd6,	// 0100011
		opImm     = 4'd7,	// 0010011
		opReg     = 4'd8,	// 0110011
		opFence   = 4'd9,	// 0001111
		opSystem  = 4'd10,	// 1110011
		opIllegal = 4'd11	// anything else
	} opClass_t;

endpackage

`default_nettype wire

//--- include/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// datapath width of pc, instruction and immediate
`define XLEN 32

// instruction memory depth in 32-bit words
`define IMEM_WORDS 256

// pc after reset and on a pcReset select
`define RESET_VECTOR 32'h0000_0000

// addi x0, x0, 0
// replaces the word fetched from a misaligned pc
`define NOP_INSTR 32'h0000_0013

`endif
